//--- Makefile
# Verilator flow for the pingpong input buffer
# any variable below can be overridden, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= pingpong_buffer_tb
RTL_TOP   ?= pingpong_buffer
FILELIST  ?= pingpong_buffer.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

# lint the design top, then the testbench top
lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --top-module $(TOP) \
	  -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

# result comes from the log, not from the exit code
sim: build
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; \
	  exit 1; \
	elif ! grep -q "TEST PASS" $(LOG); then \
	  echo "simulation ended without a result, see $(LOG)"; \
	  exit 1; \
	else \
	  echo "simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/pingpong_buffer_chk.sv
`timescale 1ns/1ps
`default_nettype none

module pingpong_buffer_chk (
  input wire i_clk_input,
  input wire i_rst_n,
  input wire i_switch,
  input wire i_ready
);

  //////////////////////////////////////////////////
  // ready flag rules
  //////////////////////////////////////////////////

  a_ready_low_after_reset: assert property (
    @(posedge i_clk_input) $rose(i_rst_n) |-> !i_ready
  ) else $error("ready high on the first cycle after reset");

  // a switch change is a swap edge in the controller
  a_ready_low_after_swap: assert property (
    @(posedge i_clk_input) disable iff (!i_rst_n)
    $changed(i_switch) |=> !i_ready
  ) else $error("ready still high after a bank swap");

  a_ready_holds: assert property (
    @(posedge i_clk_input) disable iff (!i_rst_n)
    $fell(i_ready) |-> ($past(i_switch) != $past(i_switch, 2)) || !$past(i_rst_n)
  ) else $error("ready fell without a swap or reset");

endmodule

bind pingpong_buffer pingpong_buffer_chk u_chk (
  .i_clk_input (i_clk_input),
  .i_rst_n     (i_rst_n),
  .i_switch    (i_switch_pingpong),
  .i_ready     (o_pl_buffer_ready)
);

`default_nettype wire

//--- bench/pingpong_buffer_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "pingpong_settings.svh"

module pingpong_buffer_tb;

  localparam int FRAME = `PP_FRAME_WORDS;
  localparam int READY_TIMEOUT = 64;  // cycles

  logic                 i_clk_input;
  logic                 i_rst_n;
  logic                 i_switch_pingpong;
  pingpong_pkg::pixel_t i_data_din;
  logic                 i_data_din_vld;
  pingpong_pkg::addr_t  i_conv_addr;
  logic                 o_pl_buffer_ready;
  pingpong_pkg::pixel_t o_conv_dout;

  // reference model
  pingpong_pkg::pixel_t model_a [int];  // bank_a contents
  pingpong_pkg::pixel_t model_b [int];  // bank_b contents
  pingpong_pkg::bank_e  model_fill;
  int                   model_cnt;
  logic                 model_rdy;

  // test table, one entry per row in each queue
  string row_name  [$];
  logic  row_sw    [$];
  logic  row_rst   [$];
  int    row_beats [$];
  int    row_reads [$];
  logic  row_ready [$];

  int row_errs;
  int rows_pass;
  int rows_fail;

  pingpong_buffer u_dut (
    .i_clk_input       (i_clk_input),
    .i_rst_n           (i_rst_n),
    .i_switch_pingpong (i_switch_pingpong),
    .i_data_din        (i_data_din),
    .i_data_din_vld    (i_data_din_vld),
    .o_pl_buffer_ready (o_pl_buffer_ready),
    .i_conv_addr       (i_conv_addr),
    .o_conv_dout       (o_conv_dout)
  );

  initial i_clk_input = 1'b0;
  always #20 i_clk_input = ~i_clk_input;

  //////////////////////////////////////////////////
  // table and model helpers
  //////////////////////////////////////////////////

  function automatic void add_row(input string name, input logic sw, input logic rst,
                                  input int beats, input int reads, input logic ready);
    row_name.push_back(name);
    row_sw.push_back(sw);
    row_rst.push_back(rst);
    row_beats.push_back(beats);
    row_reads.push_back(reads);
    row_ready.push_back(ready);
  endfunction

  function automatic pingpong_pkg::pixel_t model_read(input pingpong_pkg::bank_e bank,
                                                      input int idx);
    if (bank == pingpong_pkg::bank_a) begin
      return model_a[idx];
    end
    return model_b[idx];
  endfunction

  // beats past the frame end are dropped
  function automatic void model_beat(input pingpong_pkg::pixel_t pix);
    if (model_cnt < FRAME) begin
      if (model_fill == pingpong_pkg::bank_a) begin
        model_a[model_cnt] = pix;
      end else begin
        model_b[model_cnt] = pix;
      end
      model_cnt++;
      model_rdy = (model_cnt == FRAME);
    end
  endfunction

  task automatic check_pixel(input string name, input pingpong_pkg::pixel_t expected,
                             input pingpong_pkg::pixel_t actual);
    if (actual !== expected) begin
      $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
      row_errs++;
    end
  endtask

  task automatic check_ready(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("[ERROR] %s: expected ready %b, actual %b", name, expected, actual);
      row_errs++;
    end
  endtask

  task automatic wait_ready(input string name);
    int n;
    n = 0;
    while (o_pl_buffer_ready !== 1'b1 && n < READY_TIMEOUT) begin
      @(negedge i_clk_input);
      n++;
    end
    if (o_pl_buffer_ready !== 1'b1) begin
      $display("%s: buffer ready did not rise within %0d cycles", name, READY_TIMEOUT);
      row_errs++;
    end
  endtask

  //////////////////////////////////////////////////
  // one table row
  //////////////////////////////////////////////////

  task automatic run_row(input int r);
    string                name;
    int                   n;
    int                   cyc;
    logic                 exp_rdy;
    logic                 rd_now;
    logic                 rd_pend;   // read issued last cycle
    pingpong_pkg::pixel_t pix;
    pingpong_pkg::addr_t  addr;
    pingpong_pkg::bank_e  rd_bank;
    pingpong_pkg::pixel_t exp_pix;
    pingpong_pkg::pixel_t next_pix;
    name = row_name[r];
    row_errs = 0;
    if (row_rst[r]) begin
      @(posedge i_clk_input);
      i_rst_n           <= 1'b0;
      i_switch_pingpong <= 1'b0;  // bank_a fills after reset
      repeat (3) @(posedge i_clk_input);
      @(negedge i_clk_input);
      check_ready(name, 1'b0, o_pl_buffer_ready);  // cleared while reset is held
      @(posedge i_clk_input);
      i_rst_n <= 1'b1;
      model_fill = pingpong_pkg::bank_a;
      model_cnt  = 0;
      model_rdy  = 1'b0;
    end else if (row_sw[r] != (model_fill == pingpong_pkg::bank_b)) begin
      @(posedge i_clk_input);
      i_switch_pingpong <= row_sw[r];  // swap edge is the next one
      model_fill = row_sw[r] ? pingpong_pkg::bank_b : pingpong_pkg::bank_a;
      model_cnt  = 0;
      model_rdy  = 1'b0;
    end
    n = (row_beats[r] > row_reads[r]) ? row_beats[r] : row_reads[r];
    rd_pend  = 1'b0;
    exp_pix  = '0;
    next_pix = '0;
    for (cyc = 0; cyc <= n; cyc++) begin  // last pass drains the pipe
      @(posedge i_clk_input);
      exp_rdy = model_rdy;
      rd_now  = (cyc < row_reads[r]);
      if (cyc < row_beats[r]) begin
        pix = pingpong_pkg::pixel_t'($urandom);
        i_data_din     <= pix;
        i_data_din_vld <= 1'b1;
        model_beat(pix);
      end else begin
        i_data_din_vld <= 1'b0;
      end
      if (rd_now) begin
        addr = pingpong_pkg::addr_t'($urandom % FRAME);
        i_conv_addr <= addr;
        rd_bank = (model_fill == pingpong_pkg::bank_a) ? pingpong_pkg::bank_b
                                                       : pingpong_pkg::bank_a;
        next_pix = model_read(rd_bank, int'(addr));
      end
      @(negedge i_clk_input);
      check_ready(name, exp_rdy, o_pl_buffer_ready);
      if (rd_pend) begin
        check_pixel(name, exp_pix, o_conv_dout);
      end
      exp_pix = next_pix;
      rd_pend = rd_now;
    end
    if (row_ready[r]) begin
      wait_ready(name);
    end
    check_ready(name, row_ready[r], o_pl_buffer_ready);
    if (row_errs == 0) begin
      $display("%-16s ok", name);
      rows_pass++;
    end else begin
      $display("%-16s %0d mismatches", name, row_errs);
      rows_fail++;
    end
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    int r;
    void'($urandom(21926));
    i_rst_n           <= 1'b0;
    i_switch_pingpong <= 1'b0;
    i_data_din        <= '0;
    i_data_din_vld    <= 1'b0;
    i_conv_addr       <= '0;
    model_fill = pingpong_pkg::bank_a;
    model_cnt  = 0;
    model_rdy  = 1'b0;
    rows_pass  = 0;
    rows_fail  = 0;
    //       name              sw    rst   beats      reads ready
    add_row("partial_fill_a", 1'b0, 1'b0, 100,       0,    1'b0);
    add_row("full_fill_a",    1'b0, 1'b0, FRAME-100, 0,    1'b1);
    add_row("overflow_a",     1'b0, 1'b0, 40,        0,    1'b1);
    add_row("swap_read_a",    1'b1, 1'b0, FRAME,     300,  1'b1);
    add_row("swap_read_b",    1'b0, 1'b0, 200,       300,  1'b0);
    add_row("fill_b_full",    1'b1, 1'b0, FRAME,     200,  1'b1);
    add_row("reset_refill_a", 1'b0, 1'b1, FRAME,     300,  1'b1);
    repeat (16) @(posedge i_clk_input);
    i_rst_n <= 1'b1;
    for (r = 0; r < row_name.size(); r++) begin
      run_row(r);
    end
    $display("rows passed: %0d, rows failed: %0d", rows_pass, rows_fail);
    if (rows_fail == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- pingpong_buffer.f
+incdir+rtl
rtl/pingpong_pkg.sv
rtl/input_pre_sram.sv
rtl/pingpong_ctrl.sv
rtl/pingpong_buffer.sv
bench/pingpong_buffer_chk.sv
bench/pingpong_buffer_tb.sv

//--- rtl/input_pre_sram.sv
`timescale 1ns/1ps
`default_nettype none

`include "pingpong_settings.svh"

module input_pre_sram #(
  parameter int DEPTH = `PP_SRAM_DEPTH
) (
  input  wire                  i_clk_input,
  input  wire                  i_cs,
  input  wire                  i_we,
  input  wire pingpong_pkg::addr_t  i_addr,
  input  wire pingpong_pkg::pixel_t i_din,
  output pingpong_pkg::pixel_t o_dout
);

  localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  pingpong_pkg::pixel_t mem [DEPTH];
  logic [IDX_W-1:0] idx;

  assign idx = i_addr[IDX_W-1:0];  // upper address bits unused

  // single port, write wins over read
  always_ff @(posedge i_clk_input) begin
    if (i_cs) begin
      if (i_we) begin
        mem[idx] <= i_din;
      end else begin
        o_dout <= mem[idx];  // one edge read latency
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/pingpong_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module pingpong_buffer (
  input  wire                       i_clk_input,
  input  wire                       i_rst_n,
  input  wire                       i_switch_pingpong,
  input  wire pingpong_pkg::pixel_t i_data_din,
  input  wire                       i_data_din_vld,
  output logic                      o_pl_buffer_ready,
  input  wire pingpong_pkg::addr_t  i_conv_addr,
  output pingpong_pkg::pixel_t      o_conv_dout
);

  logic                 sram0_cs;
  logic                 sram0_we;
  pingpong_pkg::addr_t  sram0_addr;
  pingpong_pkg::pixel_t sram0_din;
  pingpong_pkg::pixel_t sram0_dout;

  logic                 sram1_cs;
  logic                 sram1_we;
  pingpong_pkg::addr_t  sram1_addr;
  pingpong_pkg::pixel_t sram1_din;
  pingpong_pkg::pixel_t sram1_dout;

  //////////////////////////////////////////////////
  // controller
  //////////////////////////////////////////////////

  pingpong_ctrl u_ctrl (
    .i_clk_input       (i_clk_input),
    .i_rst_n           (i_rst_n),
    .i_switch_pingpong (i_switch_pingpong),
    .i_data_din        (i_data_din),
    .i_data_din_vld    (i_data_din_vld),
    .i_conv_addr       (i_conv_addr),
    .o_pl_buffer_ready (o_pl_buffer_ready),
    .o_sram0_cs        (sram0_cs),
    .o_sram0_we        (sram0_we),
    .o_sram0_addr      (sram0_addr),
    .o_sram0_din       (sram0_din),
    .i_sram0_dout      (sram0_dout),
    .o_sram1_cs        (sram1_cs),
    .o_sram1_we        (sram1_we),
    .o_sram1_addr      (sram1_addr),
    .o_sram1_din       (sram1_din),
    .i_sram1_dout      (sram1_dout),
    .o_conv_dout       (o_conv_dout)
  );

  //////////////////////////////////////////////////
  // banks
  //////////////////////////////////////////////////

  input_pre_sram u_sram0 (  // bank_a
    .i_clk_input (i_clk_input),
    .i_cs        (sram0_cs),
    .i_we        (sram0_we),
    .i_addr      (sram0_addr),
    .i_din       (sram0_din),
    .o_dout      (sram0_dout)
  );

  input_pre_sram u_sram1 (  // bank_b
    .i_clk_input (i_clk_input),
    .i_cs        (sram1_cs),
    .i_we        (sram1_we),
    .i_addr      (sram1_addr),
    .i_din       (sram1_din),
    .o_dout      (sram1_dout)
  );

endmodule

`default_nettype wire

//--- rtl/pingpong_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "pingpong_settings.svh"

module pingpong_ctrl #(
  parameter int FRAME_WORDS = `PP_FRAME_WORDS
) (
  input  wire                       i_clk_input,
  input  wire                       i_rst_n,
  input  wire                       i_switch_pingpong,
  input  wire pingpong_pkg::pixel_t i_data_din,
  input  wire                       i_data_din_vld,
  input  wire pingpong_pkg::addr_t  i_conv_addr,
  output logic                      o_pl_buffer_ready,
  // sram0 is bank_a
  output logic                      o_sram0_cs,
  output logic                      o_sram0_we,
  output pingpong_pkg::addr_t       o_sram0_addr,
  output pingpong_pkg::pixel_t      o_sram0_din,
  input  wire pingpong_pkg::pixel_t i_sram0_dout,
  // sram1 is bank_b
  output logic                      o_sram1_cs,
  output logic                      o_sram1_we,
  output pingpong_pkg::addr_t       o_sram1_addr,
  output pingpong_pkg::pixel_t      o_sram1_din,
  input  wire pingpong_pkg::pixel_t i_sram1_dout,
  output pingpong_pkg::pixel_t      o_conv_dout
);

  localparam pingpong_pkg::addr_t FRAME_LEN = pingpong_pkg::addr_t'(FRAME_WORDS);

  logic                switch_q;   // registered copy of the switch level
  logic                run_q;      // low during and right after reset
  logic                ready_q;
  pingpong_pkg::addr_t fill_cnt;
  pingpong_pkg::bank_e fill_bank;
  pingpong_pkg::bank_e rd_bank;
  pingpong_pkg::bank_e rd_bank_q;  // bank of the read in flight
  logic                swap;
  logic                accept;
  logic                fill_a;

  //////////////////////////////////////////////////
  // bank state and fill counter
  //////////////////////////////////////////////////

  assign fill_bank = switch_q ? pingpong_pkg::bank_b : pingpong_pkg::bank_a;
  assign rd_bank   = (fill_bank == pingpong_pkg::bank_a) ? pingpong_pkg::bank_b
                                                         : pingpong_pkg::bank_a;
  assign fill_a    = (fill_bank == pingpong_pkg::bank_a);

  assign swap   = (i_switch_pingpong != switch_q);  // level change seen this edge
  // swap beats a write on the same edge
  assign accept = run_q && i_data_din_vld && (fill_cnt < FRAME_LEN) && !swap;

  always_ff @(posedge i_clk_input) begin
    if (!i_rst_n) begin
      switch_q <= 1'b0;
      run_q    <= 1'b0;
      fill_cnt <= '0;
      ready_q  <= 1'b0;
    end else begin
      run_q <= 1'b1;
      if (swap) begin
        switch_q <= i_switch_pingpong;
        fill_cnt <= '0;
        ready_q  <= 1'b0;   // new fill bank starts empty
      end else if (accept) begin
        fill_cnt <= fill_cnt + 1'b1;
        if (fill_cnt == FRAME_LEN - 1'b1) begin
          ready_q <= 1'b1;  // last beat of the frame
        end
      end
    end
  end

  assign o_pl_buffer_ready = ready_q;

  //////////////////////////////////////////////////
  // port steering
  //////////////////////////////////////////////////

  // fill bank sees the counter and the write strobe,
  // read bank sees the conv address with a read strobe
  assign o_sram0_cs   = fill_a ? accept : run_q;
  assign o_sram0_we   = fill_a & accept;
  assign o_sram0_addr = fill_a ? fill_cnt : i_conv_addr;
  assign o_sram0_din  = i_data_din;

  assign o_sram1_cs   = fill_a ? run_q : accept;
  assign o_sram1_we   = !fill_a & accept;
  assign o_sram1_addr = fill_a ? i_conv_addr : fill_cnt;
  assign o_sram1_din  = i_data_din;

  //////////////////////////////////////////////////
  // read data select
  //////////////////////////////////////////////////

  // captured with the read so a swap does not redirect it
  always_ff @(posedge i_clk_input) begin
    if (!i_rst_n) begin
      rd_bank_q <= pingpong_pkg::bank_b;
    end else begin
      rd_bank_q <= rd_bank;
    end
  end

  assign o_conv_dout = (rd_bank_q == pingpong_pkg::bank_a) ? i_sram0_dout
                                                           : i_sram1_dout;

endmodule

`default_nettype wire

//--- rtl/pingpong_pkg.sv
`default_nettype none

`include "pingpong_settings.svh"

package pingpong_pkg;

  // one pixel as it sits in a bank
  typedef logic [`PP_DATA_W-1:0] pixel_t;

  // sram word address, also used by the conv engine
  typedef logic [`PP_ADDR_W-1:0] addr_t;

  // bank currently being filled by the loader
  typedef enum logic {
    bank_a = 1'b0,  // sram0
    bank_b = 1'b1   // sram1
  } bank_e;

endpackage

`default_nettype wire

//--- rtl/pingpong_settings.svh
`ifndef PINGPONG_SETTINGS_SVH
`define PINGPONG_SETTINGS_SVH

//////////////////////////////////////////////////
// frame and bank sizing
//////////////////////////////////////////////////

`define PP_FRAME_WORDS 1155  // pixels per input frame

`define PP_SRAM_DEPTH 2048   // words per bank, at least the frame length

//////////////////////////////////////////////////
// word widths
//////////////////////////////////////////////////

`define PP_DATA_W 8   // pixel width
`define PP_ADDR_W 16  // sram and conv address width

`endif
